// File: rtl/ts_monitor_defines.svh
`ifndef TS_MONITOR_DEFINES_SVH
`define TS_MONITOR_DEFINES_SVH

// ====================
// transport packet framing.
// ====================

`define TS_PACKET_BYTES 188
`define TS_SYNC_BYTE 8'h47

// ====================
// buffer and table sizing.
// ====================

`define TS_WORD_BYTES 4
`define TS_PACKET_WORDS 47 // TS_PACKET_BYTES / TS_WORD_BYTES.
`define PID_TABLE_DEPTH 4

`endif

// File: rtl/ts_monitor_pkg.sv
`default_nettype none

package ts_monitor_pkg;

	`include "ts_monitor_defines.svh"

	// first word of a packet, byte 0 in the low lane.
	// the header bytes are big endian on the wire, so with byte 0 at the bottom
	// the PID falls into two pieces: pid_hi from byte 1 and pid_lo from byte 2.
	typedef union packed {
		logic [`TS_WORD_BYTES-1:0][7:0] bytes;
		struct packed {
			logic [1:0] scrambling; // byte 3.
			logic [1:0] adaptation;
			logic [3:0] continuity;
			logic [7:0] pid_lo;     // byte 2.
			logic       error;      // byte 1.
			logic       start;
			logic       prio;
			logic [4:0] pid_hi;
			logic [7:0] sync;       // byte 0.
		} hdr;
	} ts_header_u;

endpackage

`default_nettype wire

// File: rtl/ts_byte_if.sv
`timescale 1ns/1ps
`default_nettype none

// framed stream bytes, one per byte_valid strobe.
interface ts_byte_if;

	logic       byte_valid;
	logic [7:0] data;
	logic [7:0] index; // position in the packet, 0 to 187.
	logic       start; // high with index 0.
	logic       last;  // high with index 187.

	modport source (
		output byte_valid,
		output data,
		output index,
		output start,
		output last
	);

	modport sink (
		input byte_valid,
		input data,
		input index,
		input start,
		input last
	);

endinterface

`default_nettype wire

// File: rtl/ts_framer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ts_monitor_defines.svh"

module ts_framer (
	input  wire logic       clk,
	input  wire logic       rst_n,
	input  wire logic [7:0] ts_data,
	input  wire logic       ts_valid,
	input  wire logic       ts_sync,
	ts_byte_if.source       byte_out
);

	localparam logic [7:0] LAST_INDEX = 8'(`TS_PACKET_BYTES - 1);

	logic       in_packet;
	logic [7:0] byte_cnt; // index the next accepted byte will get.
	logic       is_start;

	// a sync byte restarts the count even in the middle of a packet.
	assign is_start = ts_valid && ts_sync && (ts_data == `TS_SYNC_BYTE);

	// ====================
	// control.
	// ====================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			in_packet           <= 1'b0;
			byte_cnt            <= '0;
			byte_out.byte_valid <= 1'b0;
			byte_out.start      <= 1'b0;
			byte_out.last       <= 1'b0;
		end else begin
			byte_out.byte_valid <= 1'b0;
			byte_out.start      <= 1'b0;
			byte_out.last       <= 1'b0;
			if (is_start) begin
				in_packet           <= 1'b1;
				byte_cnt            <= 8'd1;
				byte_out.byte_valid <= 1'b1;
				byte_out.start      <= 1'b1;
			end else if (ts_valid && in_packet) begin
				byte_out.byte_valid <= 1'b1;
				byte_out.last       <= (byte_cnt == LAST_INDEX);
				if (byte_cnt == LAST_INDEX) begin
					in_packet <= 1'b0; // wait for the next sync.
				end else begin
					byte_cnt <= byte_cnt + 8'd1;
				end
			end
		end
	end

	// ====================
	// payload.
	// ====================

	always_ff @(posedge clk) begin
		if (ts_valid) begin
			byte_out.data  <= ts_data;
			byte_out.index <= is_start ? 8'd0 : byte_cnt;
		end
	end

endmodule

`default_nettype wire

// File: rtl/pid_classifier.sv
`timescale 1ns/1ps
`default_nettype none

`include "ts_monitor_defines.svh"

module pid_classifier (
	input  wire logic        clk,
	input  wire logic        rst_n,
	ts_byte_if.sink          byte_in,
	input  wire logic        match_enable,
	input  wire logic        cfg_write,
	input  wire logic [1:0]  cfg_index,
	input  wire logic [31:0] cfg_data,
	output logic      [31:0] cfg_rdata,
	output logic             pid_hit,
	output logic             header_done
);

	import ts_monitor_pkg::*;

	logic [12:0] pid_tab [`PID_TABLE_DEPTH];
	logic        pid_en  [`PID_TABLE_DEPTH];

	ts_header_u hdr;
	ts_header_u hdr_next;
	logic       hdr_wr;
	logic [12:0] cur_pid;
	logic [`PID_TABLE_DEPTH-1:0] hit_vec;

	// ====================
	// PID table.
	// ====================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `PID_TABLE_DEPTH; i++) begin
				pid_tab[i] <= '0;
				pid_en[i]  <= 1'b0;
			end
		end else if (cfg_write && (32'(cfg_index) < `PID_TABLE_DEPTH)) begin
			pid_tab[cfg_index] <= cfg_data[12:0];
			pid_en[cfg_index]  <= cfg_data[16];
		end
	end

	// same layout as the write data.
	always_comb begin
		cfg_rdata = '0;
		if (32'(cfg_index) < `PID_TABLE_DEPTH) begin
			cfg_rdata[12:0] = pid_tab[cfg_index];
			cfg_rdata[16]   = pid_en[cfg_index];
		end
	end

	// ====================
	// header decode.
	// ====================

	assign hdr_wr = byte_in.byte_valid && (byte_in.index < 8'(`TS_WORD_BYTES));

	// merge the byte on the bus so byte 2 can be judged in its own cycle.
	always_comb begin
		hdr_next = hdr;
		if (hdr_wr) begin
			hdr_next.bytes[byte_in.index[1:0]] = byte_in.data;
		end
	end

	always_ff @(posedge clk) begin
		if (hdr_wr) begin
			hdr <= hdr_next;
		end
	end

	assign cur_pid   = {hdr_next.hdr.pid_hi, hdr_next.hdr.pid_lo};

	always_comb begin
		for (int i = 0; i < `PID_TABLE_DEPTH; i++) begin
			hit_vec[i] = pid_en[i] && (pid_tab[i] == cur_pid);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pid_hit     <= 1'b0;
			header_done <= 1'b0;
		end else begin
			header_done <= 1'b0;
			if (byte_in.byte_valid) begin
				if (byte_in.start) begin
					pid_hit <= 1'b0; // undecided until byte 2.
				end else if (byte_in.index == 8'd2) begin
					pid_hit     <= match_enable && (|hit_vec);
					header_done <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/packet_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ts_monitor_defines.svh"

module packet_buffer (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	ts_byte_if.sink                   byte_in,
	input  wire logic                 freeze,
	input  wire logic [5:0]           rd_addr,
	output ts_monitor_pkg::ts_header_u rd_data,
	output logic                      packet_done
);

	import ts_monitor_pkg::*;

	ts_header_u mem [`TS_PACKET_WORDS];

	logic [7:0] wr_word;
	logic [7:0] wr_lane;

	// byte i goes to word i/4, lane i%4.
	assign wr_word = 8'(byte_in.index / `TS_WORD_BYTES);
	assign wr_lane = 8'(byte_in.index % `TS_WORD_BYTES);

	// ====================
	// storage.
	// ====================

	always_ff @(posedge clk) begin
		if (byte_in.byte_valid && !freeze) begin
			mem[wr_word[5:0]].bytes[wr_lane[1:0]] <= byte_in.data;
		end
	end

	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr]; // one word per cycle, registered.
	end

	// ====================
	// completion.
	// ====================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			packet_done <= 1'b0;
		end else begin
			packet_done <= byte_in.byte_valid && byte_in.last;
		end
	end

endmodule

`default_nettype wire

// File: rtl/capture_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "ts_monitor_defines.svh"

module capture_control (
	input  wire logic                      clk,
	input  wire logic                      rst_n,
	input  wire logic                      dump_request,
	input  wire logic                      pid_hit,
	input  wire logic                      header_done,
	input  wire logic                      packet_done,
	input  wire ts_monitor_pkg::ts_header_u rd_data,
	output logic                           freeze,
	output logic [5:0]                     rd_addr,
	output logic [31:0]                    matched_count,
	output logic                           out_valid,
	output logic [5:0]                     out_index,
	output logic [31:0]                    out_data,
	output logic                           dump_done
);

	localparam logic [1:0] S_IDLE  = 2'd0;
	localparam logic [1:0] S_ARMED = 2'd1;
	localparam logic [1:0] S_DUMP  = 2'd2;

	localparam logic [5:0] LAST_WORD = 6'(`TS_PACKET_WORDS - 1);

	logic [1:0] state;
	logic       hdr_seen;  // header of the current packet has been decided.
	logic       rd_active; // read sweep still issuing addresses.
	logic       capture;

	assign capture  = (state == S_ARMED) && packet_done && pid_hit && hdr_seen;
	assign freeze   = (state == S_DUMP);
	assign out_data = rd_data.bytes; // read data lines up with out_valid.

	// ====================
	// matched-packet counter.
	// ====================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			matched_count <= '0;
			hdr_seen      <= 1'b0;
		end else begin
			if (packet_done && pid_hit) begin
				matched_count <= matched_count + 32'd1;
			end
			if (header_done) begin
				hdr_seen <= 1'b1;
			end else if (packet_done) begin
				hdr_seen <= 1'b0;
			end
		end
	end

	// ====================
	// capture FSM.
	// ====================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			rd_addr   <= '0;
			rd_active <= 1'b0;
			out_valid <= 1'b0;
			out_index <= '0;
			dump_done <= 1'b0;
		end else begin
			dump_done <= 1'b0;
			out_valid <= rd_active;
			out_index <= rd_addr;
			case (state)
				S_IDLE: begin
					if (dump_request) begin
						state <= S_ARMED;
					end
				end
				S_ARMED: begin
					if (capture) begin
						state     <= S_DUMP;
						rd_addr   <= '0;
						rd_active <= 1'b1;
					end
				end
				S_DUMP: begin
					if (rd_active) begin
						if (rd_addr == LAST_WORD) begin
							rd_active <= 1'b0;
						end else begin
							rd_addr <= rd_addr + 6'd1;
						end
					end
					if (out_valid && (out_index == LAST_WORD)) begin
						dump_done <= 1'b1;
						state     <= S_IDLE; // buffer is released here.
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/ts_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module ts_monitor (
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire logic [7:0]  ts_data,
	input  wire logic        ts_valid,
	input  wire logic        ts_sync,
	input  wire logic        match_enable,
	input  wire logic        cfg_write,
	input  wire logic [1:0]  cfg_index,
	input  wire logic [31:0] cfg_data,
	output logic      [31:0] cfg_rdata,
	input  wire logic        dump_request,
	output logic      [31:0] matched_count,
	output logic             out_valid,
	output logic      [5:0]  out_index,
	output logic      [31:0] out_data,
	output logic             dump_done
);

	import ts_monitor_pkg::*;

	ts_byte_if ts_bytes ();

	logic       pid_hit;
	logic       header_done;
	logic       packet_done;
	logic       freeze;
	logic [5:0] rd_addr;
	ts_header_u rd_data;

	ts_framer u_framer (
		.clk      (clk),
		.rst_n    (rst_n),
		.ts_data  (ts_data),
		.ts_valid (ts_valid),
		.ts_sync  (ts_sync),
		.byte_out (ts_bytes.source)
	);

	pid_classifier u_classifier (
		.clk          (clk),
		.rst_n        (rst_n),
		.byte_in      (ts_bytes.sink),
		.match_enable (match_enable),
		.cfg_write    (cfg_write),
		.cfg_index    (cfg_index),
		.cfg_data     (cfg_data),
		.cfg_rdata    (cfg_rdata),
		.pid_hit      (pid_hit),
		.header_done  (header_done)
	);

	packet_buffer u_buffer (
		.clk         (clk),
		.rst_n       (rst_n),
		.byte_in     (ts_bytes.sink),
		.freeze      (freeze),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.packet_done (packet_done)
	);

	capture_control u_capture (
		.clk           (clk),
		.rst_n         (rst_n),
		.dump_request  (dump_request),
		.pid_hit       (pid_hit),
		.header_done   (header_done),
		.packet_done   (packet_done),
		.rd_data       (rd_data),
		.freeze        (freeze),
		.rd_addr       (rd_addr),
		.matched_count (matched_count),
		.out_valid     (out_valid),
		.out_index     (out_index),
		.out_data      (out_data),
		.dump_done     (dump_done)
	);

endmodule

`default_nettype wire

// File: tests/ts_monitor_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "ts_monitor_defines.svh"

module ts_monitor_properties (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic dump_request,
	input wire logic out_valid,
	input wire logic dump_done
);

	int         assert_errors;
	logic [5:0] words_seen;   // out_valid cycles since the last dump_done.
	logic       request_seen; // a dump was asked for and has not finished yet.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			words_seen   <= '0;
			request_seen <= 1'b0;
		end else begin
			if (dump_done) begin
				words_seen <= '0;
			end else if (out_valid) begin
				words_seen <= words_seen + 6'd1;
			end
			if (dump_request) begin
				request_seen <= 1'b1;
			end else if (dump_done) begin
				request_seen <= 1'b0;
			end
		end
	end

	// ====================
	// output strobes.
	// ====================

	no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		!(out_valid && dump_done)) else begin
		assert_errors++;
		$error("out_valid and dump_done were high in the same cycle");
	end

	full_burst: assert property (@(posedge clk) disable iff (!rst_n)
		dump_done |-> (words_seen == 6'(`TS_PACKET_WORDS))) else begin
		assert_errors++;
		$error("dump_done came after %0d words instead of a full packet", words_seen);
	end

	requested_burst: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> request_seen) else begin
		assert_errors++;
		$error("out_valid came without an earlier dump_request");
	end

endmodule

bind ts_monitor ts_monitor_properties u_props (.*);

`default_nettype wire

// File: tests/ts_monitor_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "ts_monitor_defines.svh"

module ts_monitor_checker (
	input  wire logic         clk,
	input  wire logic         rst_n,
	input  wire logic [127:0] test_name,
	input  wire logic [7:0]   ts_data,
	input  wire logic         ts_valid,
	input  wire logic         ts_sync,
	input  wire logic         match_enable,
	input  wire logic         cfg_write,
	input  wire logic [1:0]   cfg_index,
	input  wire logic [31:0]  cfg_data,
	input  wire logic [31:0]  cfg_rdata,
	input  wire logic         dump_request,
	input  wire logic [31:0]  matched_count,
	input  wire logic         out_valid,
	input  wire logic [5:0]   out_index,
	input  wire logic [31:0]  out_data,
	input  wire logic         dump_done,
	output int                error_count
);

	logic [31:0] tab [`PID_TABLE_DEPTH]; // entries kept in the cfg_rdata layout.
	logic [7:0]  pkt [`TS_PACKET_BYTES];
	logic [7:0]  cap [`TS_PACKET_BYTES];
	logic [7:0]  idx;
	logic [7:0]  base;
	logic        in_pkt;
	logic        hit;
	logic        armed;
	logic        dumping;
	logic [5:0]  word_cnt;
	logic [31:0] exp_word;
	logic [31:0] exp_count;
	logic [31:0] count_d [2]; // the DUT counter trails the last byte by two edges.

	function automatic logic pid_listed(input logic [12:0] pid);
		logic found;
		found = 1'b0;
		for (int i = 0; i < `PID_TABLE_DEPTH; i++) begin
			if (tab[i][16] && (tab[i][12:0] == pid)) begin
				found = 1'b1;
			end
		end
		return found;
	endfunction

	task automatic mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		error_count++;
		$display("FAIL %0s %0s: expected %h, actual %h", test_name, what, expected, actual);
	endtask

	// ====================
	// compare, then advance the model.
	// ====================

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `PID_TABLE_DEPTH; i++) begin
				tab[i] = '0;
			end
			in_pkt     = 1'b0;
			idx        = '0;
			hit        = 1'b0;
			armed      = 1'b0;
			dumping    = 1'b0;
			word_cnt   = '0;
			exp_count  = '0;
			count_d[0] = '0;
			count_d[1] = '0;
		end else begin
			if (cfg_rdata !== tab[cfg_index]) begin
				mismatch("cfg_rdata", tab[cfg_index], cfg_rdata);
			end
			if (matched_count !== count_d[1]) begin
				mismatch("matched_count", count_d[1], matched_count);
			end
			if (out_valid && !dumping) begin
				error_count++;
				$display("%0s: a word came out while no packet was captured", test_name);
			end else if (out_valid) begin
				base     = {word_cnt, 2'b00}; // byte i sits in word i/4, lane i%4.
				exp_word = {cap[base + 8'd3], cap[base + 8'd2], cap[base + 8'd1], cap[base]};
				if (out_index !== word_cnt) begin
					mismatch("out_index", {26'd0, word_cnt}, {26'd0, out_index});
				end
				if (out_data !== exp_word) begin
					mismatch("out_data", exp_word, out_data);
				end
				word_cnt = word_cnt + 6'd1;
			end
			if (dump_done) begin
				if (!dumping || (word_cnt != 6'(`TS_PACKET_WORDS))) begin
					error_count++;
					$display("%0s: dump_done came after %0d words of a dump", test_name, word_cnt);
				end
				dumping  = 1'b0;
				word_cnt = '0;
			end
			count_d[1] = count_d[0];
			count_d[0] = exp_count;
			if (cfg_write) begin
				tab[cfg_index] = cfg_data & 32'h0001_1fff;
			end
			if (dump_request && !armed && !dumping) begin
				armed = 1'b1; // requests during a capture are dropped.
			end
			if (ts_valid && ts_sync && (ts_data == `TS_SYNC_BYTE)) begin
				pkt[0] = ts_data;
				idx    = 8'd1;
				in_pkt = 1'b1;
				hit    = 1'b0;
			end else if (ts_valid && in_pkt) begin
				pkt[idx] = ts_data;
				if (idx == 8'd2) begin
					hit = match_enable && pid_listed({pkt[1][4:0], ts_data});
				end
				if (idx == 8'(`TS_PACKET_BYTES - 1)) begin
					in_pkt = 1'b0;
					if (hit) begin
						exp_count = exp_count + 32'd1;
						if (armed) begin
							armed    = 1'b0;
							dumping  = 1'b1;
							word_cnt = '0;
							cap      = pkt;
						end
					end
				end else begin
					idx = idx + 8'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: tests/ts_monitor_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ts_monitor_defines.svh"

module ts_monitor_tb;

	localparam int NUM_ROWS       = 10;
	localparam int TIMEOUT_CYCLES = NUM_ROWS * 200 + 1000;

	typedef struct {
		logic [127:0] name;
		logic [12:0]  pid;
		logic         truncated; // cut short by the next packet's sync.
		logic         match_en;
		logic         dump;      // request a capture before the packet.
		logic         exp_match;
	} row_t;

	logic         clk;
	logic         rst_n;
	logic [7:0]   ts_data;
	logic         ts_valid;
	logic         ts_sync;
	logic         match_enable;
	logic         cfg_write;
	logic [1:0]   cfg_index;
	logic [31:0]  cfg_data;
	logic [31:0]  cfg_rdata;
	logic         dump_request;
	logic [31:0]  matched_count;
	logic         out_valid;
	logic [5:0]   out_index;
	logic [31:0]  out_data;
	logic         dump_done;
	logic [127:0] test_name;
	row_t         rows [NUM_ROWS];
	int           seed;
	int           cycle_count;
	int           table_errors;
	int           checker_errors;
	int           total_errors;
	logic [31:0]  exp_total;
	logic         dump_pending;

	ts_monitor DUT (.*);

	ts_monitor_checker u_checker (
		.error_count (checker_errors),
		.*
	);

	always #50 clk = ~clk;

	// ====================
	// stimulus tasks.
	// ====================

	task automatic drive_byte(input logic [7:0] data, input logic sync);
		@(posedge clk);
		#5;
		ts_data  = data;
		ts_valid = 1'b1;
		ts_sync  = sync;
	endtask

	task automatic drive_idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#5;
			ts_valid     = 1'b0;
			ts_sync      = 1'b0;
			cfg_write    = 1'b0;
			dump_request = 1'b0;
		end
	endtask

	task automatic write_entry(input logic [1:0] index, input logic [12:0] pid, input logic en);
		logic [31:0] expected;
		expected = {15'd0, en, 3'd0, pid};
		@(posedge clk);
		#5;
		cfg_write = 1'b1;
		cfg_index = index;
		cfg_data  = expected | 32'hfffe_e000; // unused bits must read back as zero.
		drive_idle(1);
		#1;
		if (cfg_rdata !== expected) begin
			table_errors++;
			$display("FAIL %0s entry %0d: expected %h, actual %h", test_name, index,
				expected, cfg_rdata);
		end
	endtask

	task automatic send_packet(input logic [12:0] pid, input logic truncated);
		int         length;
		logic [7:0] payload;
		length = truncated ? 100 : `TS_PACKET_BYTES;
		drive_byte(`TS_SYNC_BYTE, 1'b1);
		drive_byte({3'b010, pid[12:8]}, 1'b0); // start flag set.
		drive_byte(pid[7:0], 1'b0);
		drive_byte(8'h10, 1'b0);
		for (int i = 4; i < length; i++) begin
			payload = 8'($random(seed));
			drive_byte(payload, 1'b0);
		end
		drive_idle(4);
	endtask

	task automatic wait_dump_done();
		while (dump_done !== 1'b1) begin
			@(posedge clk);
		end
		drive_idle(2);
	endtask

	task automatic load_rows();
		rows[0] = '{"match_dump", 13'h0100, 1'b0, 1'b1, 1'b1, 1'b1};
		rows[1] = '{"absent_pid", 13'h0777, 1'b0, 1'b1, 1'b0, 1'b0};
		rows[2] = '{"disabled_pid", 13'h00a5, 1'b0, 1'b1, 1'b0, 1'b0};
		rows[3] = '{"enable_low", 13'h0100, 1'b0, 1'b0, 1'b0, 1'b0};
		rows[4] = '{"truncated", 13'h1234, 1'b1, 1'b1, 1'b1, 1'b0};
		rows[5] = '{"after_truncated", 13'h1234, 1'b0, 1'b1, 1'b0, 1'b1};
		rows[6] = '{"count_only_a", 13'h1fff, 1'b0, 1'b1, 1'b0, 1'b1};
		rows[7] = '{"count_only_b", 13'h0100, 1'b0, 1'b1, 1'b0, 1'b1};
		rows[8] = '{"absent_dump", 13'h0200, 1'b0, 1'b1, 1'b1, 1'b0};
		rows[9] = '{"match_after_miss", 13'h1fff, 1'b0, 1'b1, 1'b0, 1'b1};
	endtask

	// ====================
	// main sequence.
	// ====================

	initial begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		ts_data      = '0;
		ts_valid     = 1'b0;
		ts_sync      = 1'b0;
		match_enable = 1'b0;
		cfg_write    = 1'b0;
		cfg_index    = '0;
		cfg_data     = '0;
		dump_request = 1'b0;
		test_name    = "reset";
		seed         = 32'he0f3b44b;
		table_errors = 0;
		exp_total    = '0;
		dump_pending = 1'b0;
		load_rows();
		repeat (5) @(posedge clk);
		#5;
		rst_n = 1'b1;

		test_name = "cfg_readback";
		write_entry(2'd0, 13'h0100, 1'b1);
		write_entry(2'd1, 13'h1fff, 1'b1);
		write_entry(2'd2, 13'h00a5, 1'b0);
		write_entry(2'd3, 13'h1234, 1'b1);
		drive_idle(2);

		for (int r = 0; r < NUM_ROWS; r++) begin
			test_name    = rows[r].name;
			match_enable = rows[r].match_en;
			if (rows[r].dump) begin
				@(posedge clk);
				#5;
				dump_request = 1'b1;
				dump_pending = 1'b1; // an armed capture waits for the next match.
				drive_idle(1);
			end
			send_packet(rows[r].pid, rows[r].truncated);
			if (rows[r].exp_match) begin
				exp_total = exp_total + 32'd1;
			end
			if (matched_count !== exp_total) begin
				table_errors++;
				$display("FAIL %0s matched_count: expected %0d, actual %0d", test_name,
					exp_total, matched_count);
			end
			if (rows[r].exp_match && dump_pending) begin
				wait_dump_done();
				dump_pending = 1'b0;
			end
		end
		drive_idle(4);

		total_errors = checker_errors + table_errors + DUT.u_props.assert_errors;
		$display("errors: checker %0d, table %0d, assertions %0d", checker_errors,
			table_errors, DUT.u_props.assert_errors);
		if (total_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+rtl
rtl/ts_monitor_pkg.sv
rtl/ts_byte_if.sv
rtl/ts_framer.sv
rtl/pid_classifier.sv
rtl/packet_buffer.sv
rtl/capture_control.sv
rtl/ts_monitor.sv
tests/ts_monitor_properties.sv
tests/ts_monitor_checker.sv
tests/ts_monitor_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f tb.f --top-module ts_monitor_tb -o ts_monitor_sim

if ./obj_dir/ts_monitor_sim +verilator+error+limit+1000 | tee /dev/stderr \
	| grep -x "TEST RESULT: PASS" > /dev/null; then
	exit 0
else
	exit 1
fi
